//--- Makefile
# Verilator simulation of the CBM-II bus core

VERILATOR ?= verilator
TOP       ?= tb_cbm2_bus
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass line
sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
logic/cbm2_pkg.sv
logic/cycle_sequencer.sv
logic/ram_arbiter.sv
logic/video_fetch.sv
logic/tod_divider.sv
logic/cbm2_bus_top.sv
dv/tb_cbm2_bus.sv

//--- dv/tb_cbm2_bus.sv
`timescale 1ns/10ps

module tb_cbm2_bus;

   localparam int CLK_PERIOD  = 40;
   localparam int SLOTS       = cbm2_pkg::FRAME_SLOTS;
   // Frames used by all tests, the pixel wrap dominates
   localparam int TEST_FRAMES = 4200;
   localparam int WATCHDOG_NS = (TEST_FRAMES + 100) * SLOTS * CLK_PERIOD;
   // A held request is served within one frame
   localparam int CPU_LIMIT   = SLOTS;

   logic                clk_sys = 1'b0;
   logic                reset;
   logic                pause_i;
   logic                ntsc_i;
   logic [31:0]         clk_hz_i;
   logic                cpu_valid_i;
   cbm2_pkg::cpu_req_t  cpu_req_i;
   cbm2_pkg::byte_t     cpu_rdata_o;
   logic                cpu_done_o;
   cbm2_pkg::ram_req_t  ram_req_o;
   cbm2_pkg::byte_t     ram_rdata_i = '0;
   logic                refresh_o;
   logic                io_cycle_o;
   logic                pause_o;
   logic                pixel_o;
   logic                vsync_o;
   logic                tod_o;

   // RAM model and read pipeline
   cbm2_pkg::byte_t     mem [0:65535];
   cbm2_pkg::byte_t     rd_pipe = '0;

   // Frame model built from the slot rules
   int                  m_slot;
   logic [2:0]          m_rfsh;
   logic                m_en;
   logic                m_refresh;
   logic                m_vsync;
   logic                cpu_sampled;
   logic                cpu_inflight;
   cbm2_pkg::vid_addr_t m_lcnt;

   int                  vid_ce_cnt = 0;
   int                  refresh_cnt = 0;
   int                  done_cnt = 0;
   int                  io_lo_cnt = 0;
   int                  err_value = 0;
   int                  err_other = 0;
   logic [31:0]         lfsr_state = 32'h5bea_771f;

   cbm2_bus_top u_dut (
      .clk_sys     (clk_sys),
      .reset       (reset),
      .pause_i     (pause_i),
      .ntsc_i      (ntsc_i),
      .clk_hz_i    (clk_hz_i),
      .cpu_valid_i (cpu_valid_i),
      .cpu_req_i   (cpu_req_i),
      .cpu_rdata_o (cpu_rdata_o),
      .cpu_done_o  (cpu_done_o),
      .ram_req_o   (ram_req_o),
      .ram_rdata_i (ram_rdata_i),
      .refresh_o   (refresh_o),
      .io_cycle_o  (io_cycle_o),
      .pause_o     (pause_o),
      .pixel_o     (pixel_o),
      .vsync_o     (vsync_o),
      .tod_o       (tod_o)
   );

   always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

   // ==============================
   // Helpers
   // ==============================

   // Galois LFSR, one step per bit
   function logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int k = 0; k < n; k++) begin
         b          = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   // Screen byte as held in the RAM model
   function cbm2_pkg::byte_t disp_byte(input cbm2_pkg::vid_addr_t off);
      cbm2_pkg::ram_addr_t a;
      a = cbm2_pkg::VIDEO_BASE + cbm2_pkg::ram_addr_t'(off);
      return mem[a[15:0]];
   endfunction

   task check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         err_value++;
         $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task check_byte(input string name, input cbm2_pkg::byte_t got, input cbm2_pkg::byte_t exp);
      if (got !== exp) begin
         err_value++;
         $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task check_addr(input string name, input cbm2_pkg::ram_addr_t got,
                   input cbm2_pkg::ram_addr_t exp);
      if (got !== exp) begin
         err_value++;
         $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         err_value++;
         $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // ==============================
   // RAM model
   // ==============================

   // Read data shows two cycles after ce
   always @(posedge clk_sys) begin
      rd_pipe <= 8'h00;
      if (ram_req_o.ce === 1'b1) begin
         if (ram_req_o.we) mem[ram_req_o.addr[15:0]] <= ram_req_o.wdata;
         else rd_pipe <= mem[ram_req_o.addr[15:0]];
      end
      ram_rdata_i <= rd_pipe;
   end

   // ==============================
   // Frame monitor
   // ==============================

   always @(posedge clk_sys) begin
      int   eff;
      logic exp_io;
      logic exp_ce;
      if (reset) begin
         m_slot       <= 0;
         m_rfsh       <= '0;
         m_en         <= 1'b0;
         m_refresh    <= 1'b0;
         m_vsync      <= 1'b0;
         cpu_sampled  <= 1'b0;
         cpu_inflight <= 1'b0;
         m_lcnt       <= '0;
      end else begin
         // Paused frames look like EXT0 throughout
         eff    = m_en ? m_slot : 0;
         exp_io = ((eff <= 3) && (m_rfsh != 3'd1)) || ((eff >= 8) && (eff <= 11));
         exp_ce = m_en && ((m_slot == 4 && cpu_sampled) || m_slot == 12);
         check_bit("refresh_o", refresh_o, m_refresh);
         check_bit("pause_o", pause_o, ~m_en);
         check_bit("io_cycle_o", io_cycle_o, exp_io);
         check_bit("ram_req_o.ce", ram_req_o.ce, exp_ce);
         check_bit("cpu_done_o", cpu_done_o, m_en && (m_slot == 7) && cpu_inflight);
         check_bit("vsync_o", vsync_o, m_vsync);
         if (ram_req_o.ce === 1'b1 && m_en && m_slot == 12) begin
            check_addr("ram_req_o.addr video",
                       ram_req_o.addr, cbm2_pkg::VIDEO_BASE + cbm2_pkg::ram_addr_t'(m_lcnt));
            check_bit("ram_req_o.we video", ram_req_o.we, 1'b0);
            vid_ce_cnt <= vid_ce_cnt + 1;
         end
         if (exp_ce && m_slot == 4) begin
            check_addr("ram_req_o.addr cpu", ram_req_o.addr, cpu_req_i.addr);
            check_bit("ram_req_o.we", ram_req_o.we, cpu_req_i.we);
            if (cpu_req_i.we) check_byte("ram_req_o.wdata", ram_req_o.wdata, cpu_req_i.wdata);
         end
         if (refresh_o) refresh_cnt <= refresh_cnt + 1;
         if (cpu_done_o) done_cnt <= done_cnt + 1;
         if (m_en && m_slot <= 3 && !io_cycle_o) io_lo_cnt <= io_lo_cnt + 1;

         cpu_sampled <= m_en && (m_slot == 3) && cpu_valid_i;
         if (m_slot == 4) cpu_inflight <= cpu_sampled;
         // One load per enabled frame, wrap raises vsync
         m_vsync <= m_en && (m_slot == 17) && (m_lcnt == cbm2_pkg::VIDEO_CHARS - 16'd1);
         if (m_en && m_slot == 17) begin
            m_lcnt <= (m_lcnt == cbm2_pkg::VIDEO_CHARS - 16'd1) ? '0 : m_lcnt + 16'd1;
         end
         m_refresh <= 1'b0;
         if (m_slot == SLOTS - 1) begin
            m_slot <= 0;
            m_rfsh <= m_rfsh + 3'd1;
            if (m_rfsh == 3'd0) begin
               m_en      <= ~pause_i;
               m_refresh <= 1'b1;
            end
         end else begin
            m_slot <= m_slot + 1;
         end
      end
   end

   // ==============================
   // Test tasks
   // ==============================

   task wait_cpu_done(output cbm2_pkg::byte_t rdata);
      int n;
      n = 0;
      do begin
         @(posedge clk_sys);
         n++;
      end while (cpu_done_o !== 1'b1 && n < CPU_LIMIT);
      if (cpu_done_o !== 1'b1) begin
         err_other++;
         $display("ERROR: cpu_done_o did not arrive within %0d cycles at %0t", CPU_LIMIT, $time);
      end
      rdata = cpu_rdata_o;
   endtask

   task cpu_access(input cbm2_pkg::ram_addr_t addr, input logic we,
                   input cbm2_pkg::byte_t wdata, output cbm2_pkg::byte_t rdata);
      cbm2_pkg::cpu_req_t req;
      req.addr  = addr;
      req.we    = we;
      req.wdata = wdata;
      @(posedge clk_sys);
      cpu_req_i   <= req;
      cpu_valid_i <= 1'b1;
      wait_cpu_done(rdata);
      cpu_valid_i <= 1'b0;
   endtask

   task test_cpu_access;
      cbm2_pkg::ram_addr_t addr [8];
      cbm2_pkg::byte_t     data [8];
      cbm2_pkg::byte_t     rd;
      // Distinct pages keep the addresses unique
      for (int i = 0; i < 8; i++) begin
         addr[i] = cbm2_pkg::ram_addr_t'(32'h1000 + i * 256 + rand_bits(8));
         data[i] = cbm2_pkg::byte_t'(rand_bits(8));
         cpu_access(addr[i], 1'b1, data[i], rd);
      end
      for (int i = 0; i < 8; i++) begin
         cpu_access(addr[i], 1'b0, 8'h00, rd);
         check_byte("cpu_rdata_o", rd, data[i]);
      end
   endtask

   task test_slot_owner;
      int start;
      start = vid_ce_cnt;
      repeat (4 * SLOTS) @(posedge clk_sys);
      check_count("video ce per frame", vid_ce_cnt - start, 4);
   endtask

   task test_pixel_stream;
      cbm2_pkg::byte_t     b;
      cbm2_pkg::vid_addr_t loads;
      int                  n;
      n = 0;
      do begin
         @(posedge clk_sys);
         n++;
      end while (!(m_en && m_slot == 17) && n <= 2 * SLOTS);
      // Each byte comes out MSB first, two cycles per dot
      for (int f = 0; f < 40; f++) begin
         b = disp_byte(m_lcnt);
         repeat (3) @(posedge clk_sys);
         check_bit("pixel_o", pixel_o, b[7]);
         for (int k = 6; k >= 0; k--) begin
            repeat (2) @(posedge clk_sys);
            check_bit("pixel_o", pixel_o, b[k]);
         end
         @(posedge clk_sys);
      end
      n = 0;
      while (vsync_o !== 1'b1 && n < (cbm2_pkg::VIDEO_CHARS + 2) * SLOTS) begin
         @(posedge clk_sys);
         n++;
      end
      loads = '0;
      n     = 0;
      do begin
         @(posedge clk_sys);
         n++;
         if (m_en && m_slot == 17) loads = loads + 16'd1;
      end while (vsync_o !== 1'b1 && n < (cbm2_pkg::VIDEO_CHARS + 2) * SLOTS);
      if (vsync_o !== 1'b1) begin
         err_other++;
         $display("ERROR: vsync_o never pulsed after a full screen at %0t", $time);
      end
      check_count("loads between vsync", int'(loads), int'(cbm2_pkg::VIDEO_CHARS));
   endtask

   task test_refresh;
      int r0;
      int i0;
      r0 = refresh_cnt;
      i0 = io_lo_cnt;
      repeat (16 * SLOTS) @(posedge clk_sys);
      check_count("refresh pulses in 16 frames", refresh_cnt - r0, 2);
      check_count("low EXT0-3 io cycles in 16 frames", io_lo_cnt - i0, 8);
   endtask

   task wait_pause(input logic level);
      int n;
      n = 0;
      while (pause_o !== level && n <= 9 * SLOTS) begin
         @(posedge clk_sys);
         n++;
      end
      if (pause_o !== level) begin
         err_other++;
         $display("ERROR: pause_o did not reach %b within 9 frames at %0t", level, $time);
      end
   endtask

   task test_pause;
      cbm2_pkg::cpu_req_t req;
      cbm2_pkg::byte_t    rd;
      int                 d0;
      req.addr  = 25'h0_0200;
      req.we    = 1'b0;
      req.wdata = 8'h00;
      @(posedge clk_sys);
      pause_i <= 1'b1;
      wait_pause(1'b1);
      // Held request must wait out the pause
      d0 = done_cnt;
      cpu_req_i   <= req;
      cpu_valid_i <= 1'b1;
      repeat (3 * SLOTS) @(posedge clk_sys);
      check_count("cpu_done_o pulses while paused", done_cnt - d0, 0);
      pause_i <= 1'b0;
      wait_pause(1'b0);
      wait_cpu_done(rd);
      cpu_valid_i <= 1'b0;
      check_byte("cpu_rdata_o after pause", rd, mem[16'h0200]);
   endtask

   task tod_interval(output int n);
      logic last;
      last = tod_o;
      n    = 0;
      do begin
         @(posedge clk_sys);
         n++;
      end while (tod_o === last && n <= 100);
   endtask

   task test_tod;
      int n;
      // First toggle after a change carries the old remainder
      tod_interval(n);
      tod_interval(n);
      check_count("tod period ntsc", n, 10);
      ntsc_i <= 1'b0;
      tod_interval(n);
      tod_interval(n);
      check_count("tod period pal", n, 12);
   endtask

   // ==============================
   // Main sequence
   // ==============================

   initial begin
      cbm2_pkg::byte_t b;
      reset       = 1'b1;
      pause_i     = 1'b0;
      ntsc_i      = 1'b1;
      clk_hz_i    = 32'd1200;
      cpu_valid_i = 1'b0;
      cpu_req_i   = '0;
      for (int i = 0; i < 65536; i++) begin
         mem[i] = cbm2_pkg::byte_t'(i[7:0] ^ i[15:8] ^ 8'h5a);
      end
      // Random screen contents
      for (int j = 0; j < int'(cbm2_pkg::VIDEO_CHARS); j++) begin
         b = cbm2_pkg::byte_t'(rand_bits(8));
         mem[16'hD000 + j[15:0]] = b;
      end
      repeat (5) @(posedge clk_sys);
      reset <= 1'b0;
      wait_pause(1'b0);
      test_cpu_access();
      test_slot_owner();
      test_pixel_stream();
      test_refresh();
      test_pause();
      test_tod();
      $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog sized from the frame budget
   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- logic/cbm2_bus_top.sv
`timescale 1ns/10ps

module cbm2_bus_top (
   input  logic               clk_sys,
   input  logic               reset,
   input  logic               pause_i,
   input  logic               ntsc_i,
   input  logic [31:0]        clk_hz_i,
   input  logic               cpu_valid_i,
   input  cbm2_pkg::cpu_req_t cpu_req_i,
   output cbm2_pkg::byte_t    cpu_rdata_o,
   output logic               cpu_done_o,
   output cbm2_pkg::ram_req_t ram_req_o,
   input  cbm2_pkg::byte_t    ram_rdata_i,
   output logic               refresh_o,
   output logic               io_cycle_o,
   output logic               pause_o,
   output logic               pixel_o,
   output logic               vsync_o,
   output logic               tod_o
);

   // Slot and enables from the sequencer
   cbm2_pkg::slot_t     slot;
   logic                pixel_en;
   logic                sys_enable;

   // Video path between arbiter and fetcher
   cbm2_pkg::vid_addr_t vid_offset;
   cbm2_pkg::byte_t     vid_data;
   logic                vid_load;

   // ==============================
   // Cycle sequencer
   // ==============================

   cycle_sequencer u_seq (
      .clk_sys      (clk_sys),
      .reset        (reset),
      .pause_i      (pause_i),
      .slot_o       (slot),
      .pixel_en_o   (pixel_en),
      .refresh_o    (refresh_o),
      .pause_o      (pause_o),
      .io_cycle_o   (io_cycle_o),
      .sys_enable_o (sys_enable)
   );

   // ==============================
   // RAM arbiter
   // ==============================

   ram_arbiter u_arb (
      .clk_sys      (clk_sys),
      .reset        (reset),
      .slot_i       (slot),
      .cpu_valid_i  (cpu_valid_i),
      .cpu_req_i    (cpu_req_i),
      .vid_offset_i (vid_offset),
      .ram_rdata_i  (ram_rdata_i),
      .ram_req_o    (ram_req_o),
      .cpu_rdata_o  (cpu_rdata_o),
      .cpu_done_o   (cpu_done_o),
      .vid_data_o   (vid_data),
      .vid_load_o   (vid_load)
   );

   // Video fetcher and dot shifter
   video_fetch u_vid (
      .clk_sys      (clk_sys),
      .reset        (reset),
      .vid_load_i   (vid_load),
      .pixel_en_i   (pixel_en),
      .vid_data_i   (vid_data),
      .vid_offset_o (vid_offset),
      .pixel_o      (pixel_o),
      .vsync_o      (vsync_o)
   );

   // Time of day runs on enabled cycles only
   tod_divider u_tod (
      .clk_sys  (clk_sys),
      .reset    (reset),
      .enable_i (sys_enable),
      .ntsc_i   (ntsc_i),
      .clk_hz_i (clk_hz_i),
      .tod_o    (tod_o)
   );

endmodule

//--- logic/cbm2_pkg.sv
package cbm2_pkg;

   // ==============================
   // Widths
   // ==============================

   // External RAM address, 32 MiB space
   typedef logic [24:0] ram_addr_t;

   // One data byte on the RAM and CPU buses
   typedef logic [7:0]  byte_t;

   // Linear display offset from the screen start
   typedef logic [15:0] vid_addr_t;

   // Frame counter for refresh and pause alignment
   typedef logic [2:0]  rfsh_cnt_t;

   // ==============================
   // System cycle slots
   // ==============================

   // One frame is 18 slots
   // EXT slots go to the loader, CPU slots to the CPU port, VID slots to video
   typedef enum logic [4:0] {
      SLOT_EXT0, SLOT_EXT1, SLOT_EXT2, SLOT_EXT3,
      SLOT_CPU0, SLOT_CPU1, SLOT_CPU2, SLOT_CPU3,
      SLOT_EXT4, SLOT_EXT5, SLOT_EXT6, SLOT_EXT7,
      SLOT_VID0, SLOT_VID1, SLOT_VID2, SLOT_VID3,
      SLOT_VID4, SLOT_VID5
   } slot_t;

   localparam int unsigned FRAME_SLOTS = 18;

   // ==============================
   // Video and time of day
   // ==============================

   // Display start in RAM
   localparam ram_addr_t VIDEO_BASE = 25'h00_D000;

   // 80 columns by 25 rows
   localparam vid_addr_t VIDEO_CHARS = 16'd2000;

   // Accumulator steps, twice the mains rate since tod toggles
   localparam logic [31:0] TOD_HZ_NTSC = 32'd120;
   localparam logic [31:0] TOD_HZ_PAL  = 32'd100;

   // ==============================
   // Bus structs
   // ==============================

   // CPU port request, held by the requester as a level
   typedef struct packed {
      ram_addr_t addr;
      logic      we;
      byte_t     wdata;
   } cpu_req_t;

   // Request towards the external RAM
   typedef struct packed {
      ram_addr_t addr;
      logic      ce;
      logic      we;
      byte_t     wdata;
   } ram_req_t;

endpackage

//--- logic/cycle_sequencer.sv
`timescale 1ns/10ps

module cycle_sequencer (
   input  logic            clk_sys,
   input  logic            reset,
   input  logic            pause_i,
   output cbm2_pkg::slot_t slot_o,
   output logic            pixel_en_o,
   output logic            refresh_o,
   output logic            pause_o,
   output logic            io_cycle_o,
   output logic            sys_enable_o
);

   // Free-running slot, not gated by pause
   cbm2_pkg::slot_t     pre_slot;
   cbm2_pkg::rfsh_cnt_t rfsh_cnt;

   // Pixel phase, counts cycles from frame start
   logic [1:0]          pix_phase;

   logic                frame_end;
   logic                ext_lo_slot;
   logic                ext_hi_slot;

   // Last slot of the frame
   assign frame_end = (pre_slot == cbm2_pkg::slot_t'(cbm2_pkg::FRAME_SLOTS - 1));

   // ==============================
   // Slot counter
   // ==============================

   // Steps every cycle, even while paused
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pre_slot <= cbm2_pkg::SLOT_EXT0;
      end else if (frame_end) begin
         pre_slot <= cbm2_pkg::SLOT_EXT0;
      end else begin
         pre_slot <= cbm2_pkg::slot_t'(pre_slot + 5'd1);
      end
   end

   // ==============================
   // Refresh and pause
   // ==============================

   // Pause and refresh only move on an 8-frame boundary
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         rfsh_cnt     <= '0;
         sys_enable_o <= 1'b0;
         refresh_o    <= 1'b0;
      end else begin
         refresh_o <= 1'b0;
         if (frame_end) begin
            rfsh_cnt <= rfsh_cnt + 3'd1;
            if (rfsh_cnt == '0) begin
               sys_enable_o <= ~pause_i;
               // Shows up in the first cycle of the next frame
               refresh_o    <= 1'b1;
            end
         end
      end
   end

   // Paused frames park every peer on EXT0
   assign slot_o  = sys_enable_o ? pre_slot : cbm2_pkg::SLOT_EXT0;
   assign pause_o = ~sys_enable_o;

   // ==============================
   // Loader slots
   // ==============================

   // EXT0 is the first slot, so only the upper bound matters
   assign ext_lo_slot = (slot_o <= cbm2_pkg::SLOT_EXT3);
   assign ext_hi_slot = (slot_o >= cbm2_pkg::SLOT_EXT4) && (slot_o <= cbm2_pkg::SLOT_EXT7);

   // Low EXT slots are lent to refresh in frame 1 of 8
   assign io_cycle_o = (ext_lo_slot && (rfsh_cnt != 3'd1)) || ext_hi_slot;

   // ==============================
   // Pixel enable
   // ==============================

   // Cleared at frame end so EXT0 is count zero
   always_ff @(posedge clk_sys) begin
      if (reset || !sys_enable_o || frame_end) begin
         pix_phase <= 2'd0;
      end else begin
         pix_phase <= pix_phase + 2'd1;
      end
   end

   // Odd counts give a dot every other cycle
   assign pixel_en_o = pix_phase[0];

endmodule

//--- logic/ram_arbiter.sv
`timescale 1ns/10ps

module ram_arbiter (
   input  logic               clk_sys,
   input  logic               reset,
   input  cbm2_pkg::slot_t    slot_i,
   input  logic               cpu_valid_i,
   input  cbm2_pkg::cpu_req_t cpu_req_i,
   input  cbm2_pkg::vid_addr_t vid_offset_i,
   input  cbm2_pkg::byte_t    ram_rdata_i,
   output cbm2_pkg::ram_req_t ram_req_o,
   output cbm2_pkg::byte_t    cpu_rdata_o,
   output logic               cpu_done_o,
   output cbm2_pkg::byte_t    vid_data_o,
   output logic               vid_load_o
);

   cbm2_pkg::ram_addr_t req_addr;
   cbm2_pkg::byte_t     req_wdata;
   logic                req_ce;
   logic                req_we;

   // CPU access in flight this frame
   logic                cpu_busy;

   // ==============================
   // Request payload
   // ==============================

   // Loaded one slot early so the request is on the bus during CPU0 or VID0
   // EXT3 and EXT7 only occur in enabled frames
   always_ff @(posedge clk_sys) begin
      if (slot_i == cbm2_pkg::SLOT_EXT3 && cpu_valid_i) begin
         req_addr  <= cpu_req_i.addr;
         req_wdata <= cpu_req_i.wdata;
      end else if (slot_i == cbm2_pkg::SLOT_EXT7) begin
         req_addr  <= cbm2_pkg::VIDEO_BASE + cbm2_pkg::ram_addr_t'(vid_offset_i);
         req_wdata <= '0;
      end

      // Read data is valid two cycles after ce
      if (slot_i == cbm2_pkg::SLOT_CPU2 && cpu_busy) begin
         cpu_rdata_o <= ram_rdata_i;
      end
      if (slot_i == cbm2_pkg::SLOT_VID2) begin
         vid_data_o <= ram_rdata_i;
      end
   end

   // ==============================
   // Slot ownership and strobes
   // ==============================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         req_ce     <= 1'b0;
         req_we     <= 1'b0;
         cpu_busy   <= 1'b0;
         cpu_done_o <= 1'b0;
         vid_load_o <= 1'b0;
      end else begin
         req_ce     <= 1'b0;
         req_we     <= 1'b0;
         cpu_done_o <= 1'b0;
         vid_load_o <= 1'b0;
         case (slot_i)
            // CPU owns CPU0 when a request is held
            cbm2_pkg::SLOT_EXT3: begin
               if (cpu_valid_i) begin
                  req_ce   <= 1'b1;
                  req_we   <= cpu_req_i.we;
                  cpu_busy <= 1'b1;
               end
            end
            // Done shows in CPU3 with the captured byte
            cbm2_pkg::SLOT_CPU2: begin
               if (cpu_busy) begin
                  cpu_done_o <= 1'b1;
                  cpu_busy   <= 1'b0;
               end
            end
            // Video reads at VID0 in every enabled frame
            cbm2_pkg::SLOT_EXT7: req_ce <= 1'b1;
            // Load strobe lands in VID5
            cbm2_pkg::SLOT_VID4: vid_load_o <= 1'b1;
            default: ;
         endcase
      end
   end

   assign ram_req_o.addr  = req_addr;
   assign ram_req_o.ce    = req_ce;
   assign ram_req_o.we    = req_we;
   assign ram_req_o.wdata = req_wdata;

endmodule

//--- logic/tod_divider.sv
`timescale 1ns/10ps

module tod_divider (
   input  logic        clk_sys,
   input  logic        reset,
   input  logic        enable_i,
   input  logic        ntsc_i,
   input  logic [31:0] clk_hz_i,
   output logic        tod_o
);

   // Fractional phase of the tod clock
   logic [31:0] acc;
   logic [31:0] step;
   logic [31:0] acc_sum;

   // 60 Hz or 50 Hz mains rate
   assign step    = ntsc_i ? cbm2_pkg::TOD_HZ_NTSC : cbm2_pkg::TOD_HZ_PAL;
   assign acc_sum = acc + step;

   // ==============================
   // Accumulator
   // ==============================

   // Only system-enabled cycles count, so pause stops the clock
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         acc   <= '0;
         tod_o <= 1'b0;
      end else if (enable_i) begin
         if (acc_sum >= clk_hz_i) begin
            // Keep the remainder so the rate stays exact
            acc   <= acc_sum - clk_hz_i;
            tod_o <= ~tod_o;
         end else begin
            acc <= acc_sum;
         end
      end
   end

endmodule

//--- logic/video_fetch.sv
`timescale 1ns/10ps

module video_fetch (
   input  logic                clk_sys,
   input  logic                reset,
   input  logic                vid_load_i,
   input  logic                pixel_en_i,
   input  cbm2_pkg::byte_t     vid_data_i,
   output cbm2_pkg::vid_addr_t vid_offset_o,
   output logic                pixel_o,
   output logic                vsync_o
);

   // Dot shift register, MSB goes out first
   cbm2_pkg::byte_t dot;

   // Last character cell of the screen
   logic            last_char;

   assign last_char = (vid_offset_o == (cbm2_pkg::VIDEO_CHARS - 16'd1));

   // ==============================
   // Display address
   // ==============================

   // One character per frame, offset moves on each load
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         vid_offset_o <= '0;
         vsync_o      <= 1'b0;
      end else begin
         vsync_o <= 1'b0;
         if (vid_load_i) begin
            if (last_char) begin
               // Screen done, back to the top
               vid_offset_o <= '0;
               vsync_o      <= 1'b1;
            end else begin
               vid_offset_o <= vid_offset_o + 16'd1;
            end
         end
      end
   end

   // ==============================
   // Dot shifter
   // ==============================

   // Load wins over shift, they meet in VID5
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         dot <= '0;
      end else if (vid_load_i) begin
         dot <= vid_data_i;
      end else if (pixel_en_i) begin
         dot <= {dot[6:0], 1'b0};
      end
   end

   // Output register, follows the MSB on each dot
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pixel_o <= 1'b0;
      end else if (pixel_en_i) begin
         pixel_o <= dot[7];
      end
   end

endmodule
